//--- Bender.yml
package:
  name: pal_test

sources:
  - files:
      - logic/pal_test_pkg.sv
      - logic/ps2_port.sv
      - logic/key_mode_ctrl.sv
      - logic/tone_gen.sv
      - logic/bar_gen.sv
      - logic/pal_test_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_pal_test.sv

//--- logic/bar_gen.sv
`timescale 1ns/1ps
`default_nettype none

module bar_gen (
    input  wire                      clk7,
    input  wire                      rst_n,
    input  wire pal_test_pkg::video_std_t std,
    output pal_test_pkg::video_out_t vid
);

    logic [8:0] hcnt;
    logic [8:0] vcnt;
    pal_test_pkg::video_std_t std_lat;

    logic [8:0] line_clks;
    logic [8:0] frame_lines;
    logic       line_end;
    logic       frame_end;

    logic       hsync_on;
    logic       vsync_on;
    logic       active;
    logic [8:0] offset;
    logic [2:0] bar_idx;
    logic [2:0] colour;

    ////////////////////////////////////////////////////////////////////////////
    // Raster counters
    ////////////////////////////////////////////////////////////////////////////

    // Geometry follows the latched standard only
    assign line_clks   = (std_lat == pal_test_pkg::STD_NTSC) ?
                         pal_test_pkg::NTSC_LINE_CLKS : pal_test_pkg::PAL_LINE_CLKS;
    assign frame_lines = (std_lat == pal_test_pkg::STD_NTSC) ?
                         pal_test_pkg::NTSC_FRAME_LINES : pal_test_pkg::PAL_FRAME_LINES;

    assign line_end  = (hcnt == line_clks - 9'd1);
    assign frame_end = line_end && (vcnt == frame_lines - 9'd1);

    always_ff @(posedge clk7) begin
        if (!rst_n) begin
            hcnt    <= '0;
            vcnt    <= '0;
            std_lat <= pal_test_pkg::STD_PAL;
        end else if (line_end) begin
            hcnt <= '0;
            if (frame_end) begin
                vcnt    <= '0;
                // New standard starts on a clean frame
                std_lat <= std;
            end else begin
                vcnt <= vcnt + 9'd1;
            end
        end else begin
            hcnt <= hcnt + 9'd1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Sync and bar decode
    ////////////////////////////////////////////////////////////////////////////

    // Line sync at the start of every line
    assign hsync_on = (hcnt < pal_test_pkg::HSYNC_CLKS);
    // Whole lines low at the top of the frame
    assign vsync_on = (vcnt < pal_test_pkg::VSYNC_LINES);

    assign active = (hcnt >= pal_test_pkg::ACTIVE_START) &&
                    (hcnt < pal_test_pkg::ACTIVE_END);
    assign offset = hcnt - pal_test_pkg::ACTIVE_START;

    // Only meaningful inside the active window
    assign bar_idx = 3'(offset / pal_test_pkg::BAR_CLKS);

    // 7 - k, white first and black last
    assign colour = 3'd7 - bar_idx;

    // Registered pixel, one cycle behind the counters
    always_ff @(posedge clk7) begin
        if (!rst_n) begin
            vid <= '0;
        end else begin
            vid.csync <= !(hsync_on || vsync_on);
            if (active && !vsync_on) begin
                // G on bit 2, R on bit 1, B on bit 0
                vid.g <= {3{colour[2]}};
                vid.r <= {3{colour[1]}};
                vid.b <= {3{colour[0]}};
            end else begin
                vid.r <= '0;
                vid.g <= '0;
                vid.b <= '0;
            end
        end
    end

    a_hcnt_range: assert property (@(posedge clk7) disable iff (!rst_n)
        hcnt < line_clks);

endmodule

`default_nettype wire

//--- logic/key_mode_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module key_mode_ctrl (
    input  wire                      clk7,
    input  wire                      rst_n,
    input  wire                      key_valid,
    input  wire pal_test_pkg::key_event_t key,
    output pal_test_pkg::video_std_t std,
    output logic                     stdn,
    output logic                     stdnb
);

    logic plain_press;

    // Plain presses only, no release and no E0 keys
    assign plain_press = key_valid && !key.released && !key.extended;

    // P picks PAL, N picks NTSC, anything else keeps the mode
    always_ff @(posedge clk7) begin
        if (!rst_n) begin
            std <= pal_test_pkg::STD_PAL;
        end else if (plain_press) begin
            case (key.scancode)
                pal_test_pkg::KEY_P: std <= pal_test_pkg::STD_PAL;
                pal_test_pkg::KEY_N: std <= pal_test_pkg::STD_NTSC;
                default:             std <= std;
            endcase
        end
    end

    // Encoder standard select, low for PAL
    assign stdn  = (std == pal_test_pkg::STD_NTSC);
    // PAL clock enable
    assign stdnb = ~stdn;

    a_std_pair: assert property (@(posedge clk7) disable iff (!rst_n)
        stdnb == !stdn);

endmodule

`default_nettype wire

//--- logic/pal_test_pkg.sv
`default_nettype none

package pal_test_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////////////////////

    // Selected video standard, also the stdn pin level
    typedef enum logic {
        STD_PAL  = 1'b0,
        STD_NTSC = 1'b1
    } video_std_t;

    // One decoded key with its prefix flags
    typedef struct packed {
        logic [7:0] scancode;
        logic       released;
        logic       extended;
    } key_event_t;

    // Pixel out, 3 bits per channel plus composite sync
    typedef struct packed {
        logic [2:0] r;
        logic [2:0] g;
        logic [2:0] b;
        logic       csync;
    } video_out_t;

    // PS/2 receive frame states
    typedef enum logic [2:0] {
        RX_IDLE,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } ps2_state_t;

    ////////////////////////////////////////////////////////////////////////////
    // Constants
    ////////////////////////////////////////////////////////////////////////////

    // Set 2 scancodes
    localparam logic [7:0] KEY_P           = 8'h4D;
    localparam logic [7:0] KEY_N           = 8'h31;
    localparam logic [7:0] PREFIX_RELEASE  = 8'hF0;
    localparam logic [7:0] PREFIX_EXTENDED = 8'hE0;

    // Line length in clk7 cycles
    localparam logic [8:0] PAL_LINE_CLKS    = 9'd448;
    localparam logic [8:0] NTSC_LINE_CLKS   = 9'd444;
    // Frame length in lines
    localparam logic [8:0] PAL_FRAME_LINES  = 9'd312;
    localparam logic [8:0] NTSC_FRAME_LINES = 9'd262;

    // Sync and picture window
    localparam logic [8:0] HSYNC_CLKS   = 9'd32;
    localparam logic [8:0] VSYNC_LINES  = 9'd3;
    localparam logic [8:0] ACTIVE_START = 9'd96;
    localparam logic [8:0] BAR_CLKS     = 9'd40;
    // Eight bars, first clock past the last one
    localparam logic [8:0] ACTIVE_END   = ACTIVE_START + 9'd8 * BAR_CLKS;

    // 7 MHz / (2 * 3500) = 1 kHz
    localparam logic [11:0] TONE_HALF_PERIOD = 12'd3500;

    // Samples a PS/2 line must hold before a new level is taken
    localparam logic [2:0] PS2_FILTER_LEN = 3'd4;

endpackage

`default_nettype wire

//--- logic/pal_test_top.sv
`timescale 1ns/1ps
`default_nettype none

module pal_test_top (
    input  wire        clk7,
    input  wire        rst_n,
    input  wire        clkps2,
    input  wire        dataps2,
    output logic [2:0] r,
    output logic [2:0] g,
    output logic [2:0] b,
    output logic       csync,
    output logic       audio_out_left,
    output logic       audio_out_right,
    output logic       stdn,
    output logic       stdnb
);

    logic                     key_valid;
    pal_test_pkg::key_event_t key;
    pal_test_pkg::video_std_t std;
    pal_test_pkg::video_out_t vid;
    logic                     audio;

    ////////////////////////////////////////////////////////////////////////////
    // Keyboard and mode select
    ////////////////////////////////////////////////////////////////////////////

    ps2_port u_ps2_port (
        .clk7        (clk7),
        .rst_n       (rst_n),
        .ps2clk_ext  (clkps2),
        .ps2data_ext (dataps2),
        .key_valid   (key_valid),
        .key         (key)
    );

    key_mode_ctrl u_key_mode_ctrl (
        .clk7      (clk7),
        .rst_n     (rst_n),
        .key_valid (key_valid),
        .key       (key),
        .std       (std),
        .stdn      (stdn),
        .stdnb     (stdnb)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Picture and sound
    ////////////////////////////////////////////////////////////////////////////

    bar_gen u_bar_gen (
        .clk7  (clk7),
        .rst_n (rst_n),
        .std   (std),
        .vid   (vid)
    );

    tone_gen u_tone_gen (
        .clk7  (clk7),
        .rst_n (rst_n),
        .audio (audio)
    );

    // Pixel bus out to the pins
    assign r     = vid.r;
    assign g     = vid.g;
    assign b     = vid.b;
    assign csync = vid.csync;

    // Same tone on both channels
    assign audio_out_left  = audio;
    assign audio_out_right = audio;

endmodule

`default_nettype wire

//--- logic/ps2_port.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_port (
    input  wire                     clk7,
    input  wire                     rst_n,
    input  wire                     ps2clk_ext,
    input  wire                     ps2data_ext,
    output logic                    key_valid,
    output pal_test_pkg::key_event_t key
);

    // Bit 0 is the clock line, bit 1 the data line
    logic [1:0] sync_a;
    logic [1:0] sync_b;
    logic [1:0] filt;
    logic [1:0] filt_q;
    logic [2:0] flt_cnt [2];

    pal_test_pkg::ps2_state_t state;
    logic [7:0] shreg;
    logic [2:0] bit_cnt;
    logic       parity_ok;
    logic       rel_flag;
    logic       ext_flag;

    logic clk_fall;
    logic data_bit;
    logic frame_ok;
    logic is_prefix;

    ////////////////////////////////////////////////////////////////////////////
    // Line conditioning
    ////////////////////////////////////////////////////////////////////////////

    // Two-flop sync, then a hold filter per line
    // Lines idle high
    always_ff @(posedge clk7) begin
        if (!rst_n) begin
            sync_a <= 2'b11;
            sync_b <= 2'b11;
            filt   <= 2'b11;
            filt_q <= 2'b11;
            for (int i = 0; i < 2; i++) begin
                flt_cnt[i] <= '0;
            end
        end else begin
            sync_a <= {ps2data_ext, ps2clk_ext};
            sync_b <= sync_a;
            filt_q <= filt;
            for (int i = 0; i < 2; i++) begin
                // Any sample back at the old level restarts the count
                if (sync_b[i] == filt[i]) begin
                    flt_cnt[i] <= '0;
                end else if (flt_cnt[i] == pal_test_pkg::PS2_FILTER_LEN - 3'd1) begin
                    filt[i]    <= sync_b[i];
                    flt_cnt[i] <= '0;
                end else begin
                    flt_cnt[i] <= flt_cnt[i] + 3'd1;
                end
            end
        end
    end

    // Keyboard changes data on the rising edge, we sample on the falling one
    assign clk_fall = filt_q[0] & ~filt[0];
    assign data_bit = filt[1];

    ////////////////////////////////////////////////////////////////////////////
    // Frame receiver
    ////////////////////////////////////////////////////////////////////////////

    // Good stop bit after good parity
    assign frame_ok  = clk_fall && (state == pal_test_pkg::RX_STOP) && data_bit && parity_ok;
    assign is_prefix = (shreg == pal_test_pkg::PREFIX_RELEASE) ||
                       (shreg == pal_test_pkg::PREFIX_EXTENDED);

    always_ff @(posedge clk7) begin
        if (!rst_n) begin
            state     <= pal_test_pkg::RX_IDLE;
            bit_cnt   <= '0;
            parity_ok <= 1'b0;
            rel_flag  <= 1'b0;
            ext_flag  <= 1'b0;
            key_valid <= 1'b0;
        end else begin
            key_valid <= 1'b0;
            if (clk_fall) begin
                case (state)
                    pal_test_pkg::RX_IDLE: begin
                        // Start bit is low
                        if (!data_bit) begin
                            state   <= pal_test_pkg::RX_DATA;
                            bit_cnt <= '0;
                        end
                    end
                    pal_test_pkg::RX_DATA: begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= pal_test_pkg::RX_PARITY;
                        end
                    end
                    pal_test_pkg::RX_PARITY: begin
                        // Odd parity over data plus parity bit
                        parity_ok <= ^{shreg, data_bit};
                        state     <= pal_test_pkg::RX_STOP;
                    end
                    pal_test_pkg::RX_STOP: begin
                        state <= pal_test_pkg::RX_IDLE;
                        if (frame_ok && shreg == pal_test_pkg::PREFIX_RELEASE) begin
                            rel_flag <= 1'b1;
                        end else if (frame_ok && shreg == pal_test_pkg::PREFIX_EXTENDED) begin
                            ext_flag <= 1'b1;
                        end else begin
                            // Delivered key or broken frame, flags start over
                            key_valid <= frame_ok;
                            rel_flag  <= 1'b0;
                            ext_flag  <= 1'b0;
                        end
                    end
                    default: state <= pal_test_pkg::RX_IDLE;
                endcase
            end
        end
    end

    // LSB first into the top of the shifter
    always_ff @(posedge clk7) begin
        if (clk_fall && state == pal_test_pkg::RX_DATA) begin
            shreg <= {data_bit, shreg[7:1]};
        end
        if (frame_ok && !is_prefix) begin
            key.scancode <= shreg;
            key.released <= rel_flag;
            key.extended <= ext_flag;
        end
    end

    // Strobe is a single cycle
    a_valid_single: assert property (@(posedge clk7) disable iff (!rst_n)
        key_valid |=> !key_valid);

    // Prefix bytes never reach the controller
    a_no_prefix: assert property (@(posedge clk7) disable iff (!rst_n)
        key_valid |-> (key.scancode != pal_test_pkg::PREFIX_RELEASE &&
                       key.scancode != pal_test_pkg::PREFIX_EXTENDED));

endmodule

`default_nettype wire

//--- logic/tone_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tone_gen (
    input  wire  clk7,
    input  wire  rst_n,
    output logic audio
);

    logic [11:0] div;
    logic        wrap;

    // Last count of a half period
    assign wrap = (div == pal_test_pkg::TONE_HALF_PERIOD - 12'd1);

    // Half-period divider
    // Audio flips on each wrap
    always_ff @(posedge clk7) begin
        if (!rst_n) begin
            div   <= '0;
            audio <= 1'b0;
        end else if (wrap) begin
            div   <= '0;
            audio <= ~audio;
        end else begin
            div   <= div + 12'd1;
        end
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+test
logic/pal_test_pkg.sv
logic/ps2_port.sv
logic/key_mode_ctrl.sv
logic/tone_gen.sv
logic/bar_gen.sv
logic/pal_test_top.sv
test/tb_pal_test.sv

//--- test/tb_ps2_host.svh
// Keyboard clock half-period in clk7 cycles
localparam int PS2_HALF = 10;

////////////////////////////////////////////////////////////////////////////
// Keyboard frames
////////////////////////////////////////////////////////////////////////////

// Start, eight data bits LSB first, odd parity, stop
// Data moves while the clock is high, host samples on the fall
task automatic send_byte(input logic [7:0] code, input logic bad_parity);
    logic [10:0] frame;
    int          i;
    frame = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
    for (i = 0; i < 11; i++) begin
        dataps2 = frame[i];
        step(PS2_HALF);
        clkps2 = 1'b0;
        step(PS2_HALF);
        clkps2 = 1'b1;
    end
    // Idle high before the next frame
    dataps2 = 1'b1;
    step(PS2_HALF);
endtask

////////////////////////////////////////////////////////////////////////////
// Filler keys
////////////////////////////////////////////////////////////////////////////

// 16-bit Fibonacci LFSR, taps 16 14 13 11, shifting right
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[0] ^ s[2] ^ s[3] ^ s[5], s[15:1]};
endfunction

// One LFSR step per bit, eight bits per key
// Mode keys and prefixes are drawn again
task automatic next_filler_key(output logic [7:0] code);
    logic again;
    int   i;
    again = 1'b1;
    code  = '0;
    while (again) begin
        for (i = 0; i < 8; i++) begin
            code       = {lfsr_state[0], code[7:1]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        again = (code == pal_test_pkg::KEY_P) ||
                (code == pal_test_pkg::KEY_N) ||
                (code == pal_test_pkg::PREFIX_RELEASE) ||
                (code == pal_test_pkg::PREFIX_EXTENDED);
    end
endtask

//--- test/tb_pal_test.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pal_test;

    // Two PAL frames, one NTSC frame, key traffic and slack
    localparam int PAL_FRAME  = int'(pal_test_pkg::PAL_FRAME_LINES) *
                                int'(pal_test_pkg::PAL_LINE_CLKS);
    localparam int NTSC_FRAME = int'(pal_test_pkg::NTSC_FRAME_LINES) *
                                int'(pal_test_pkg::NTSC_LINE_CLKS);
    localparam int CYCLE_LIMIT = 2 * PAL_FRAME + NTSC_FRAME + 10000 + 14120;
    localparam int TONE = int'(pal_test_pkg::TONE_HALF_PERIOD);
    localparam int HSYNC = int'(pal_test_pkg::HSYNC_CLKS);

    logic       clk7;
    logic       rst_n;
    logic       clkps2;
    logic       dataps2;
    logic [2:0] r;
    logic [2:0] g;
    logic [2:0] b;
    logic       csync;
    logic       audio_out_left;
    logic       audio_out_right;
    logic       stdn;
    logic       stdnb;
    logic [8:0] rgb;

    int          error_count;
    int          key_checks;
    int          cycle_count;
    logic        exp_stdn;
    logic        check_req;
    logic [15:0] lfsr_state;

    // Raster tracking from csync alone
    logic cs_q;
    logic fall_ev;
    logic rise_ev;
    logic seen_fall;
    logic line_ok;
    logic fall_std;
    logic frame_std;
    int   run;
    int   last_low;
    int   pos;
    int   fall_count;
    int   long_rises;

    // Tone tracking
    logic aud_q;
    int   gap;

    pal_test_top u_pal_test_top (
        .clk7            (clk7),
        .rst_n           (rst_n),
        .clkps2          (clkps2),
        .dataps2         (dataps2),
        .r               (r),
        .g               (g),
        .b               (b),
        .csync           (csync),
        .audio_out_left  (audio_out_left),
        .audio_out_right (audio_out_right),
        .stdn            (stdn),
        .stdnb           (stdnb)
    );

    `include "tb_ps2_host.svh"

    initial begin
        clk7 = 1'b0;
        forever #50 clk7 = ~clk7;
    end

    always @(posedge clk7) begin
        cycle_count <= cycle_count + 1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    // Inputs move 10 ns after the edge
    task step(input int n);
        repeat (n) @(posedge clk7);
        #10;
    endtask

    task check_stdn();
        check_req = 1'b1;
        key_checks++;
        step(1);
        check_req = 1'b0;
    endtask

    task report_error(input string msg);
        error_count++;
        $display("[ERROR] %0t ns: %s", $time, msg);
    endtask

    task print_summary();
        $display("Summary: %0d key checks, %0d frame starts, %0d errors",
                 key_checks, long_rises, error_count);
    endtask

    function automatic int line_len_of(input logic ntsc);
        return ntsc ? int'(pal_test_pkg::NTSC_LINE_CLKS) : int'(pal_test_pkg::PAL_LINE_CLKS);
    endfunction

    function automatic int frame_len_of(input logic ntsc);
        return ntsc ? int'(pal_test_pkg::NTSC_FRAME_LINES) :
                      int'(pal_test_pkg::PAL_FRAME_LINES);
    endfunction

    // Bar table as {r, g, b}, white down to black
    function automatic logic [8:0] bar_rgb(input int offset);
        int k;
        if (offset < 96 || offset >= 96 + 8 * 40) begin
            return 9'o000;
        end
        k = (offset - 96) / 40;
        case (k)
            0: return 9'o777;
            1: return 9'o770;
            2: return 9'o077;
            3: return 9'o070;
            4: return 9'o707;
            5: return 9'o700;
            6: return 9'o007;
            default: return 9'o000;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Raster and tone trackers
    ////////////////////////////////////////////////////////////////////////////

    assign rgb     = {r, g, b};
    assign fall_ev = cs_q & ~csync;
    assign rise_ev = ~cs_q & csync;

    always @(posedge clk7) begin
        if (!rst_n) begin
            cs_q       <= 1'b0;
            run        <= 0;
            last_low   <= 0;
            pos        <= 0;
            seen_fall  <= 1'b0;
            line_ok    <= 1'b0;
            fall_count <= 0;
            long_rises <= 0;
            fall_std   <= 1'b0;
            frame_std  <= 1'b0;
        end else begin
            cs_q <= csync;
            run  <= (fall_ev || rise_ev) ? 1 : run + 1;
            pos  <= fall_ev ? 1 : pos + 1;
            if (fall_ev) begin
                seen_fall  <= 1'b1;
                line_ok    <= 1'b0;
                fall_count <= fall_count + 1;
                // Standard the key record holds at this line start
                fall_std   <= exp_stdn;
            end
            if (rise_ev) begin
                last_low <= run;
                if (run == HSYNC) begin
                    line_ok <= 1'b1;
                end else begin
                    // Long low, new frame under way
                    long_rises <= long_rises + 1;
                    fall_count <= 0;
                    frame_std  <= fall_std;
                end
            end
        end
    end

    // Cycles since the last audio change
    always @(posedge clk7) begin
        if (!rst_n) begin
            aud_q <= 1'b0;
            gap   <= 0;
        end else begin
            aud_q <= audio_out_left;
            gap   <= (audio_out_left != aud_q) ? 1 : gap + 1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    a_reset_state: assert property (@(posedge clk7)
        $rose(rst_n) |-> (!stdn && stdnb && !audio_out_left))
        else report_error("state after reset is not PAL with audio low");

    a_std_pins: assert property (@(posedge clk7) disable iff (!rst_n)
        stdnb == !stdn)
        else report_error("stdnb is not the inverse of stdn");

    a_key_model: assert property (@(posedge clk7) disable iff (!rst_n)
        check_req |-> stdn == exp_stdn)
        else report_error($sformatf("stdn is %0b, expected %0b",
                                    $sampled(stdn), $sampled(exp_stdn)));

    a_audio_pair: assert property (@(posedge clk7) disable iff (!rst_n)
        audio_out_left == audio_out_right)
        else report_error("left and right audio differ");

    a_tone_step: assert property (@(posedge clk7) disable iff (!rst_n)
        $changed(audio_out_left) |-> gap == TONE)
        else report_error($sformatf("audio toggled after %0d cycles", $sampled(gap)));

    a_tone_late: assert property (@(posedge clk7) disable iff (!rst_n)
        gap <= TONE)
        else report_error("audio held longer than a half period");

    a_sync_width: assert property (@(posedge clk7) disable iff (!rst_n)
        (rise_ev && seen_fall) |->
            (run == HSYNC || run == int'(pal_test_pkg::VSYNC_LINES) *
                                    line_len_of(fall_std) + HSYNC))
        else report_error($sformatf("csync low for %0d cycles", $sampled(run)));

    a_line_len: assert property (@(posedge clk7) disable iff (!rst_n)
        (fall_ev && seen_fall && last_low == HSYNC) |->
            (last_low + run == line_len_of(frame_std)))
        else report_error($sformatf("line of %0d cycles, expected %0d",
                                    $sampled(last_low + run), line_len_of(frame_std)));

    a_frame_len: assert property (@(posedge clk7) disable iff (!rst_n)
        (rise_ev && run != HSYNC && long_rises >= 1) |->
            (fall_count + int'(pal_test_pkg::VSYNC_LINES) == frame_len_of(frame_std)))
        else report_error($sformatf("frame of %0d lines, expected %0d",
                                    $sampled(fall_count) + 3, frame_len_of(frame_std)));

    a_black_sync: assert property (@(posedge clk7) disable iff (!rst_n)
        !csync |-> rgb == 9'o000)
        else report_error("RGB not black while csync is low");

    a_bars: assert property (@(posedge clk7) disable iff (!rst_n)
        (csync && line_ok) |-> rgb == bar_rgb(pos))
        else report_error($sformatf("RGB %o at offset %0d, expected %o",
                                    $sampled(rgb), $sampled(pos), bar_rgb($sampled(pos))));

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [7:0] filler;
        rst_n       = 1'b0;
        clkps2      = 1'b1;
        dataps2     = 1'b1;
        check_req   = 1'b0;
        exp_stdn    = 1'b0;
        error_count = 0;
        key_checks  = 0;
        cycle_count = 0;
        lfsr_state  = 16'd6301;
        step(5);
        rst_n = 1'b1;
        step(20);
        check_stdn();

        // Plain N then P
        send_byte(pal_test_pkg::KEY_N, 1'b0);
        exp_stdn = 1'b1;
        check_stdn();
        send_byte(pal_test_pkg::KEY_P, 1'b0);
        exp_stdn = 1'b0;
        check_stdn();

        // Release and extended N leave PAL
        send_byte(pal_test_pkg::PREFIX_RELEASE, 1'b0);
        send_byte(pal_test_pkg::KEY_N, 1'b0);
        check_stdn();
        send_byte(pal_test_pkg::PREFIX_EXTENDED, 1'b0);
        send_byte(pal_test_pkg::KEY_N, 1'b0);
        check_stdn();

        // Other keys in NTSC mode
        send_byte(pal_test_pkg::KEY_N, 1'b0);
        exp_stdn = 1'b1;
        check_stdn();
        repeat (6) begin
            next_filler_key(filler);
            send_byte(filler, 1'b0);
            check_stdn();
        end
        send_byte(pal_test_pkg::KEY_P, 1'b0);
        exp_stdn = 1'b0;
        check_stdn();

        // Bad parity N dropped, clean N taken
        send_byte(pal_test_pkg::KEY_N, 1'b1);
        check_stdn();
        send_byte(pal_test_pkg::KEY_N, 1'b0);
        exp_stdn = 1'b1;
        check_stdn();
        send_byte(pal_test_pkg::KEY_P, 1'b0);
        exp_stdn = 1'b0;
        check_stdn();

        // Frame 1 runs PAL, N early in it makes frame 2 NTSC
        wait (long_rises == 2);
        step(1);
        send_byte(pal_test_pkg::KEY_N, 1'b0);
        exp_stdn = 1'b1;
        check_stdn();
        // Frame 3 start closes the NTSC frame check
        wait (long_rises == 4);
        step(2);

        print_summary();
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        wait (cycle_count >= CYCLE_LIMIT);
        $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
        print_summary();
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire
